//--- logic/spmd_pkg.sv
// spmd host link definitions
package spmd_pkg;

  // data word and word address widths
  localparam int DATA_W = 32;
  localparam int ADDR_W = 6;  // 64 words of dmem

  // global cycle counter width
  localparam int CTR_W = 32;

  // link packet opcodes
  typedef enum logic [1:0] {
    OP_STORE      = 2'b00,
    OP_LOAD       = 2'b01,
    OP_PRINT_STAT = 2'b10,
    OP_FINISH     = 2'b11
  } link_op_e;

  // link packet, 40 bits
  // [39:38] op, [37:32] addr, [31:0] data
  typedef struct packed {
    link_op_e            op;
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   data;  // store data or print-stat tag
  } link_pkt_t;

endpackage

//--- logic/mc_link_if.sv
// manycore link channel
`timescale 1ns/1ps

interface mc_link_if
  import spmd_pkg::*;
  ();

  logic              valid;
  logic              ready;  // level, independent of valid
  link_op_e          op;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] data;

  // packet producer side
  modport sender (
    output valid
    ,output op
    ,output addr
    ,output data
    ,input  ready
  );

  // packet consumer side
  modport receiver (
    input   valid
    ,input  op
    ,input  addr
    ,input  data
    ,output ready
  );

endinterface

//--- logic/reset_sequencer.sv
// tag phase and core reset chain
`timescale 1ns/1ps

module reset_sequencer
  import spmd_pkg::*;
  #(parameter int dmem_size_p   = 64
    ,parameter int reset_depth_p = 3
  )
  (input  logic              clk_i
   ,input  logic              rst_n_i
   ,output logic              clr_en_o
   ,output logic [ADDR_W-1:0] clr_addr_o
   ,output logic              core_reset_o
  );

  logic [ADDR_W-1:0]        clr_cnt_r;
  logic                     tag_done_r;
  logic [reset_depth_p-1:0] chain_r;

  // walk dmem once, one word per cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      clr_cnt_r  <= '0;
      tag_done_r <= 1'b0;
    end else if (!tag_done_r) begin
      clr_cnt_r <= clr_cnt_r + 1'b1;
      if (clr_cnt_r == ADDR_W'(dmem_size_p - 1))
        tag_done_r <= 1'b1;  // last word cleared
    end
  end

  assign clr_en_o   = ~tag_done_r;
  assign clr_addr_o = clr_cnt_r;

  // tag done delayed by reset_depth_p stages
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      chain_r <= '0;
    end else begin
      chain_r[0] <= tag_done_r;
      for (int i = 1; i < reset_depth_p; i++)
        chain_r[i] <= chain_r[i-1];
    end
  end

  assign core_reset_o = ~chain_r[reset_depth_p-1];

endmodule

//--- logic/spmd_loader.sv
// host request loader
`timescale 1ns/1ps

module spmd_loader
  import spmd_pkg::*;
  (input  logic              clk_i
   ,input  logic              rst_n_i
   ,input  logic              core_reset_i
   ,input  logic              host_v_i
   ,input  link_op_e          host_op_i
   ,input  logic [ADDR_W-1:0] host_addr_i
   ,input  logic [DATA_W-1:0] host_data_i
   ,output logic              host_ready_o
   ,mc_link_if.sender         link_o
   ,input  logic              done_i
  );

  link_pkt_t pkt_r;
  logic      pkt_v_r;
  logic      closed_r;  // finish already taken
  logic      accept;
  logic      send;

  assign send   = pkt_v_r & link_o.ready;
  assign accept = host_v_i & host_ready_o;

  // register free, or emptied this cycle
  assign host_ready_o = ~core_reset_i & ~closed_r & ~done_i
                        & (~pkt_v_r | link_o.ready);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pkt_v_r  <= 1'b0;
      closed_r <= 1'b0;
    end else if (core_reset_i) begin
      pkt_v_r  <= 1'b0;
      closed_r <= 1'b0;
    end else begin
      if (accept)
        pkt_v_r <= 1'b1;
      else if (send)
        pkt_v_r <= 1'b0;

      // nothing may follow a finish
      if (accept && (host_op_i == OP_FINISH))
        closed_r <= 1'b1;
    end
  end

  // packet payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      pkt_r.op   <= host_op_i;
      pkt_r.addr <= host_addr_i;
      pkt_r.data <= host_data_i;
    end
  end

  assign link_o.valid = pkt_v_r;
  assign link_o.op    = pkt_r.op;
  assign link_o.addr  = pkt_r.addr;
  assign link_o.data  = pkt_r.data;

endmodule

//--- logic/link_fifo.sv
// link packet fifo
`timescale 1ns/1ps

module link_fifo
  import spmd_pkg::*;
  #(parameter int fifo_depth_p = 4
  )
  (input  logic        clk_i
   ,input  logic        rst_n_i
   ,input  logic        core_reset_i
   ,mc_link_if.receiver in_link
   ,mc_link_if.sender   out_link
  );

  localparam int PTR_W = (fifo_depth_p > 1) ? $clog2(fifo_depth_p) : 1;
  localparam int CNT_W = $clog2(fifo_depth_p + 1);

  link_pkt_t        mem_r [fifo_depth_p];
  logic [PTR_W-1:0] wr_ptr_r;
  logic [PTR_W-1:0] rd_ptr_r;
  logic [CNT_W-1:0] count_r;
  logic             push;
  logic             pop;

  assign in_link.ready  = ~core_reset_i & (count_r != CNT_W'(fifo_depth_p));
  assign out_link.valid = (count_r != '0);

  assign push = in_link.valid & in_link.ready;
  assign pop  = out_link.valid & out_link.ready;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else if (core_reset_i) begin
      wr_ptr_r <= '0;  // flush
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (push)
        wr_ptr_r <= (wr_ptr_r == PTR_W'(fifo_depth_p - 1)) ? '0 : wr_ptr_r + 1'b1;
      if (pop)
        rd_ptr_r <= (rd_ptr_r == PTR_W'(fifo_depth_p - 1)) ? '0 : rd_ptr_r + 1'b1;
      case ({push, pop})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;  // none, or both
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_r[wr_ptr_r].op   <= in_link.op;
      mem_r[wr_ptr_r].addr <= in_link.addr;
      mem_r[wr_ptr_r].data <= in_link.data;
    end
  end

  assign out_link.op   = mem_r[rd_ptr_r].op;
  assign out_link.addr = mem_r[rd_ptr_r].addr;
  assign out_link.data = mem_r[rd_ptr_r].data;

endmodule

//--- logic/tile_endpoint.sv
// tile endpoint with data memory
`timescale 1ns/1ps

module tile_endpoint
  import spmd_pkg::*;
  #(parameter int dmem_size_p = 64
  )
  (input  logic              clk_i
   ,input  logic              rst_n_i
   ,input  logic              core_reset_i
   ,input  logic              clr_en_i
   ,input  logic [ADDR_W-1:0] clr_addr_i
   ,mc_link_if.receiver       link_i
   ,output logic              rsp_v_o
   ,output logic [DATA_W-1:0] rsp_data_o
   ,output logic              print_stat_v_o
   ,output logic [DATA_W-1:0] print_stat_tag_o
   ,output logic [CTR_W-1:0]  print_stat_ctr_o
   ,output logic              done_o
  );

  logic [DATA_W-1:0] dmem_r [dmem_size_p];
  logic [CTR_W-1:0]  ctr_r;
  logic              pop;
  logic              is_store;
  logic              is_load;
  logic              is_stat;
  logic              is_finish;
  logic              rsp_v_r;
  logic              stat_v_r;
  logic              done_r;
  logic [DATA_W-1:0] rsp_data_r;
  logic [DATA_W-1:0] stat_tag_r;
  logic [CTR_W-1:0]  stat_ctr_r;

  assign link_i.ready = ~core_reset_i;  // one packet per cycle
  assign pop          = link_i.valid & link_i.ready;

  // opcode decode
  always_comb begin
    is_store  = 1'b0;
    is_load   = 1'b0;
    is_stat   = 1'b0;
    is_finish = 1'b0;
    case (link_i.op)
      OP_STORE:      is_store  = pop;
      OP_LOAD:       is_load   = pop;
      OP_PRINT_STAT: is_stat   = pop;
      OP_FINISH:     is_finish = pop;
      default:       is_store  = 1'b0;
    endcase
  end

  // tag phase clear has priority
  always_ff @(posedge clk_i) begin
    if (clr_en_i)
      dmem_r[clr_addr_i] <= '0;
    else if (is_store)
      dmem_r[link_i.addr] <= link_i.data;
  end

  // global cycle counter, zero while in core reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i)
      ctr_r <= '0;
    else if (core_reset_i)
      ctr_r <= '0;
    else
      ctr_r <= ctr_r + 1'b1;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_v_r  <= 1'b0;
      stat_v_r <= 1'b0;
      done_r   <= 1'b0;
    end else if (core_reset_i) begin
      rsp_v_r  <= 1'b0;
      stat_v_r <= 1'b0;
      done_r   <= 1'b0;
    end else begin
      rsp_v_r  <= is_load;   // single cycle pulse
      stat_v_r <= is_stat;
      if (is_finish)
        done_r <= 1'b1;      // sticky
    end
  end

  always_ff @(posedge clk_i) begin
    if (is_load)
      rsp_data_r <= dmem_r[link_i.addr];
    if (is_stat) begin
      stat_tag_r <= link_i.data;
      stat_ctr_r <= ctr_r;
    end
  end

  assign rsp_v_o          = rsp_v_r;
  assign rsp_data_o       = rsp_data_r;
  assign print_stat_v_o   = stat_v_r;
  assign print_stat_tag_o = stat_tag_r;
  assign print_stat_ctr_o = stat_ctr_r;
  assign done_o           = done_r;

endmodule

//--- logic/spmd_host_top.sv
// spmd host harness top level
`timescale 1ns/1ps

module spmd_host_top
  import spmd_pkg::*;
  #(parameter int dmem_size_p   = 64
    ,parameter int fifo_depth_p  = 4
    ,parameter int reset_depth_p = 3
  )
  (input  logic              clk_i
   ,input  logic              rst_n_i

   // host requests
   ,input  logic              host_v_i
   ,input  link_op_e          host_op_i
   ,input  logic [ADDR_W-1:0] host_addr_i
   ,input  logic [DATA_W-1:0] host_data_i
   ,output logic              host_ready_o

   // load responses
   ,output logic              rsp_v_o
   ,output logic [DATA_W-1:0] rsp_data_o

   // print-stat events
   ,output logic              print_stat_v_o
   ,output logic [DATA_W-1:0] print_stat_tag_o
   ,output logic [CTR_W-1:0]  print_stat_ctr_o

   ,output logic              done_o
   ,output logic              reset_o
  );

  logic              core_reset;
  logic              clr_en;
  logic [ADDR_W-1:0] clr_addr;
  logic              done;

  mc_link_if ld2fifo ();
  mc_link_if fifo2ep ();

  // core reset released after dmem clear
  reset_sequencer #(
    .dmem_size_p(dmem_size_p)
    ,.reset_depth_p(reset_depth_p)
  ) u_reset_sequencer (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.clr_en_o(clr_en)
    ,.clr_addr_o(clr_addr)
    ,.core_reset_o(core_reset)
  );

  spmd_loader u_spmd_loader (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.core_reset_i(core_reset)
    ,.host_v_i(host_v_i)
    ,.host_op_i(host_op_i)
    ,.host_addr_i(host_addr_i)
    ,.host_data_i(host_data_i)
    ,.host_ready_o(host_ready_o)
    ,.link_o(ld2fifo)
    ,.done_i(done)
  );

  link_fifo #(
    .fifo_depth_p(fifo_depth_p)
  ) u_link_fifo (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.core_reset_i(core_reset)
    ,.in_link(ld2fifo)
    ,.out_link(fifo2ep)
  );

  tile_endpoint #(
    .dmem_size_p(dmem_size_p)
  ) u_tile_endpoint (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.core_reset_i(core_reset)
    ,.clr_en_i(clr_en)
    ,.clr_addr_i(clr_addr)
    ,.link_i(fifo2ep)
    ,.rsp_v_o(rsp_v_o)
    ,.rsp_data_o(rsp_data_o)
    ,.print_stat_v_o(print_stat_v_o)
    ,.print_stat_tag_o(print_stat_tag_o)
    ,.print_stat_ctr_o(print_stat_ctr_o)
    ,.done_o(done)
  );

  assign done_o  = done;
  assign reset_o = core_reset;

endmodule

//--- verif/spmd_host_asserts.sv
// link and status protocol checks
`timescale 1ns/1ps

module spmd_host_asserts
  (input  logic clk_i
   ,input  logic rst_n_i
   ,input  logic core_reset_i
   ,input  logic ld_valid_i
   ,input  logic ld_ready_i
   ,input  logic ep_valid_i
   ,input  logic ep_ready_i
   ,input  logic host_ready_i
   ,input  logic rsp_v_i
   ,input  logic print_stat_v_i
   ,input  logic done_i
  );

  // no transfer on either link in core reset
  ld_idle_in_reset: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    core_reset_i |-> !ld_valid_i && !(ld_valid_i && ld_ready_i))
    else $error("loader link valid during core reset");

  ep_idle_in_reset: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    core_reset_i |-> !ep_valid_i && !(ep_valid_i && ep_ready_i))
    else $error("endpoint link valid during core reset");

  done_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    done_i |=> done_i)
    else $error("done fell after it was set");

  // nothing is left in flight once done is set
  closed_after_done: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    done_i |-> !host_ready_i && !ld_valid_i && !ep_valid_i)
    else $error("host ready or link traffic while done is high");

  // one event kind per cycle and only after a pop
  rsp_stat_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (rsp_v_i || print_stat_v_i) |->
      !(rsp_v_i && print_stat_v_i) && $past(ep_valid_i && ep_ready_i))
    else $error("response or print-stat event without a single matching pop");

endmodule

bind spmd_host_top spmd_host_asserts u_spmd_host_asserts (
  .clk_i(clk_i)
  ,.rst_n_i(rst_n_i)
  ,.core_reset_i(core_reset)
  ,.ld_valid_i(ld2fifo.valid)
  ,.ld_ready_i(ld2fifo.ready)
  ,.ep_valid_i(fifo2ep.valid)
  ,.ep_ready_i(fifo2ep.ready)
  ,.host_ready_i(host_ready_o)
  ,.rsp_v_i(rsp_v_o)
  ,.print_stat_v_i(print_stat_v_o)
  ,.done_i(done_o)
);

//--- verif/spmd_host_tb.sv
// spmd host harness testbench
`timescale 1ns/1ps

module spmd_host_tb
  import spmd_pkg::*;
  ();

  localparam int NUM_REQ     = 300;
  localparam int SEQ_CYCLES  = 67;  // dmem clear plus release chain
  localparam int CYCLE_LIMIT = NUM_REQ * 8 + SEQ_CYCLES + 200;

  logic              clk;
  logic              rst_n;
  logic              host_v;
  link_op_e          host_op;
  logic [ADDR_W-1:0] host_addr;
  logic [DATA_W-1:0] host_data;
  logic              host_ready;
  logic              rsp_v;
  logic [DATA_W-1:0] rsp_data;
  logic              stat_v;
  logic [DATA_W-1:0] stat_tag;
  logic [CTR_W-1:0]  stat_ctr;
  logic              done;
  logic              reset;

  // reference model
  logic [DATA_W-1:0] model_mem [64];
  logic [DATA_W-1:0] rsp_q [$];
  logic [DATA_W-1:0] tag_q [$];
  logic [CTR_W-1:0]  model_ctr = '0;  // cycles since reset_o fell
  logic [CTR_W-1:0]  last_ctr = '0;
  logic              stat_seen = 1'b0;
  logic              done_seen = 1'b0;
  logic              finish_sent = 1'b0;
  logic [15:0]       lfsr_q = 16'd23981;
  int                errors = 0;
  int                cycles = 0;
  int                issued = 0;    // loads and print-stats sent
  int                returned = 0;

  spmd_host_top u_spmd_host_top (
    .clk_i(clk)
    ,.rst_n_i(rst_n)
    ,.host_v_i(host_v)
    ,.host_op_i(host_op)
    ,.host_addr_i(host_addr)
    ,.host_data_i(host_data)
    ,.host_ready_o(host_ready)
    ,.rsp_v_o(rsp_v)
    ,.rsp_data_o(rsp_data)
    ,.print_stat_v_o(stat_v)
    ,.print_stat_tag_o(stat_tag)
    ,.print_stat_ctr_o(stat_ctr)
    ,.done_o(done)
    ,.reset_o(reset)
  );

  // galois lfsr stepped once per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    logic        lsb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lsb    = lfsr_q[0];
      lfsr_q = lfsr_q >> 1;
      if (lsb)
        lfsr_q = lfsr_q ^ 16'hB400;
      val = {val[30:0], lsb};
    end
    return val;
  endfunction

  task automatic check_sequence(input logic exp_reset);
    assert (reset == exp_reset) else begin
      $display("Fail reset_o: got %h, expected %h", reset, exp_reset);
      errors++;
    end
    if (exp_reset) begin
      assert (!host_ready && !rsp_v && !stat_v && !done) else begin
        $display("outputs went active while the core was held in reset");
        errors++;
      end
    end
  endtask

  task automatic check_outputs();
    logic [DATA_W-1:0] exp;
    assert (!done || finish_sent) else begin
      $display("done_o rose before the finish request was sent");
      errors++;
    end
    if (done_seen) begin
      assert (done) else begin
        $display("done_o fell after it was set");
        errors++;
      end
    end
    // input closes as soon as the finish is taken
    if (finish_sent) begin
      assert (!host_ready) else begin
        $display("Fail host_ready_o: got %h, expected %h", host_ready, 1'b0);
        errors++;
      end
    end
    if (done) begin
      done_seen = 1'b1;
      assert (!rsp_v && !stat_v) else begin
        $display("a response or print-stat event appeared after finish");
        errors++;
      end
    end
    if (rsp_v) begin
      returned++;
      assert (rsp_q.size() > 0) else begin
        $display("load response arrived with no load pending");
        errors++;
      end
      if (rsp_q.size() > 0) begin
        exp = rsp_q.pop_front();
        assert (rsp_data == exp) else begin
          $display("Fail rsp_data_o: got %h, expected %h", rsp_data, exp);
          errors++;
        end
      end
    end
    if (stat_v) begin
      returned++;
      assert (tag_q.size() > 0) else begin
        $display("print-stat event arrived with none pending");
        errors++;
      end
      if (tag_q.size() > 0) begin
        exp = tag_q.pop_front();
        assert (stat_tag == exp) else begin
          $display("Fail print_stat_tag_o: got %h, expected %h", stat_tag, exp);
          errors++;
        end
      end
      assert (!stat_seen || stat_ctr > last_ctr) else begin
        $display("Fail print_stat_ctr_o: got %h, previous %h", stat_ctr, last_ctr);
        errors++;
      end
      assert (stat_ctr <= model_ctr) else begin
        $display("Fail print_stat_ctr_o: got %h, model counter %h", stat_ctr, model_ctr);
        errors++;
      end
      stat_seen = 1'b1;
      last_ctr  = stat_ctr;
    end
  endtask

  // model updated at drive time
  task automatic issue_request(input link_op_e op);
    host_v    = 1'b1;
    host_op   = op;
    host_addr = ADDR_W'(take_bits(ADDR_W));
    host_data = take_bits(DATA_W);
    case (op)
      OP_STORE: model_mem[host_addr] = host_data;
      OP_LOAD: begin
        rsp_q.push_back(model_mem[host_addr]);
        issued++;
      end
      OP_PRINT_STAT: begin
        tag_q.push_back(host_data);
        issued++;
      end
      default: finish_sent = 1'b1;
    endcase
  endtask

  task automatic step_cycle();
    @(negedge clk);
    model_ctr++;
    check_outputs();
    host_v = 1'b0;
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    link_op_e op;
    int       sent;
    rst_n     = 1'b0;
    host_v    = 1'b0;
    host_op   = OP_STORE;
    host_addr = '0;
    host_data = '0;
    sent      = 0;
    for (int a = 0; a < 64; a++)
      model_mem[a] = '0;  // dmem is cleared in the tag phase

    repeat (8) begin
      @(negedge clk);
      check_sequence(1'b1);
    end
    rst_n = 1'b1;
    for (int i = 1; i <= SEQ_CYCLES; i++) begin
      @(negedge clk);
      check_sequence(i < SEQ_CYCLES);
    end

    while (sent < NUM_REQ) begin
      step_cycle();
      if (host_ready && take_bits(2) != 0) begin
        if (sent == NUM_REQ - 1) begin
          op = OP_FINISH;
        end else begin
          op = link_op_e'(take_bits(2));
          if (op == OP_FINISH)
            op = OP_STORE;
        end
        issue_request(op);
        sent++;
      end
    end

    while (!done_seen)
      step_cycle();
    repeat (20) step_cycle();  // quiet window after finish

    assert (rsp_q.size() == 0 && tag_q.size() == 0) else begin
      $display("requests were left without a response or event");
      errors++;
    end
    assert (returned == issued) else begin
      $display("Fail returned count: got %h, expected %h", returned, issued);
      errors++;
    end

    $display("errors: %0d", errors);
    if (errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("run timed out after %0d cycles", cycles);
      $display("errors: %0d", errors);
      $display("Simulation failed");
      $finish;
    end
  end

endmodule

//--- sources.f
logic/spmd_pkg.sv
logic/mc_link_if.sv
logic/reset_sequencer.sv
logic/spmd_loader.sv
logic/link_fifo.sv
logic/tile_endpoint.sv
logic/spmd_host_top.sv
verif/spmd_host_asserts.sv
verif/spmd_host_tb.sv
